// ==== logic/rp_sig_pkg.sv ====
/*
  Sample types for the two-channel analog path.
  Holds the raw converter code, the signed sample, the channel pairs and the
  code conversion and saturation helpers that the signal-path blocks import.
*/

package rp_sig_pkg;

  localparam int SMP_W = 14;                       // converter resolution
  localparam int SUM_W = SMP_W + 1;                // mixer sum, one guard bit

  localparam int SMP_MAX = 2**(SMP_W-1) - 1;       // largest sample
  localparam int SMP_MIN = -(2**(SMP_W-1));        // smallest sample

  typedef logic        [SMP_W-1:0] adc_code_t;     // negative-slope offset code
  typedef logic signed [SMP_W-1:0] sample_t;       // two's complement

  // one sample per channel
  typedef struct packed {
    sample_t a;
    sample_t b;
  } chan_pair_t;

  // one raw code per channel, used on both ADC and DAC side
  typedef struct packed {
    adc_code_t a;
    adc_code_t b;
  } dac_pair_t;

  // msb kept, rest inverted, same rule in both directions
  function automatic sample_t code_to_smp(input adc_code_t c);
    return {c[SMP_W-1], ~c[SMP_W-2:0]};
  endfunction

  function automatic adc_code_t smp_to_code(input sample_t s);
    return {s[SMP_W-1], ~s[SMP_W-2:0]};
  endfunction

  // clip a wide intermediate back into sample range
  function automatic sample_t sat_smp(input int v);
    if (v > SMP_MAX) return sample_t'(SMP_MAX);
    if (v < SMP_MIN) return sample_t'(SMP_MIN);
    return sample_t'(v);
  endfunction

endpackage

// ==== logic/rp_cfg_pkg.sv ====
/*
  Register map and configuration types of the analog core.
  The APB register file fills core_cfg_t, the signal blocks read it.
*/

package rp_cfg_pkg;

  localparam int APB_AW = 12;                      // byte address
  localparam int APB_DW = 32;

  // register offsets
  localparam logic [APB_AW-1:0] REG_CTRL  = 12'h000; // loop, enables
  localparam logic [APB_AW-1:0] REG_ID    = 12'h004; // read only
  localparam logic [APB_AW-1:0] REG_SP_A  = 12'h010;
  localparam logic [APB_AW-1:0] REG_SP_B  = 12'h014;
  localparam logic [APB_AW-1:0] REG_KP_A  = 12'h018;
  localparam logic [APB_AW-1:0] REG_KP_B  = 12'h01C;
  localparam logic [APB_AW-1:0] REG_OFS_A = 12'h020;
  localparam logic [APB_AW-1:0] REG_OFS_B = 12'h024;
  localparam logic [APB_AW-1:0] REG_AMP   = 12'h028; // square amplitude
  localparam logic [APB_AW-1:0] REG_HALF  = 12'h02C; // half period, cycles

  localparam logic [APB_DW-1:0] CORE_ID = 32'h5250_0001;

  localparam int KP_SHIFT = 6;                     // gain is fixed point, 6 frac bits
  localparam int HALF_W   = 16;

  typedef logic signed [7:0] kp_t;

  // everything the signal path needs, straight from the registers
  typedef struct packed {
    logic                 dig_loop;   // DAC back into ADC path
    logic                 ctl_a_en;
    logic                 ctl_b_en;
    logic                 sq_en;      // square wave on
    rp_sig_pkg::sample_t  sp_a;       // setpoints
    rp_sig_pkg::sample_t  sp_b;
    kp_t                  kp_a;       // gains
    kp_t                  kp_b;
    rp_sig_pkg::sample_t  ofs_a;      // DC offsets
    rp_sig_pkg::sample_t  ofs_b;
    rp_sig_pkg::sample_t  amp;        // shared by both channels
    logic [HALF_W-1:0]    half;
  } core_cfg_t;

endpackage

// ==== logic/adc_frontend.sv ====
/*
  ADC capture for both channels.
  Pins pass two register stages, then the negative-slope code becomes a
  signed sample. Digital loop swaps in the mixer output instead.
*/

`timescale 1ns/10ps

module adc_frontend
  import rp_sig_pkg::*, rp_cfg_pkg::*;
(
  input  logic       adc_clk,
  input  logic       arst_n_i,
  input  adc_code_t  adc_a_i,
  input  adc_code_t  adc_b_i,
  input  core_cfg_t  cfg_i,
  input  chan_pair_t loop_i,     // registered mixer result
  output chan_pair_t smp_o
);

  dac_pair_t raw_q;   // first stage next to the pins
  dac_pair_t raw_qq;  // second stage

  //////////////////////////////////////////////////////////////////////
  // two-stage pin capture
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      raw_q  <= '0;
      raw_qq <= '0;
    end else begin
      raw_q.a <= adc_a_i;
      raw_q.b <= adc_b_i;
      raw_qq  <= raw_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // conversion and loopback select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (cfg_i.dig_loop) begin
      smp_o = loop_i;                    // DAC data seen as input
    end else begin
      smp_o.a = code_to_smp(raw_qq.a);
      smp_o.b = code_to_smp(raw_qq.b);
    end
  end

endmodule

// ==== logic/prop_ctrl.sv ====
/*
  Proportional controller, one per channel.
  Output is kp * (setpoint - input) >> KP_SHIFT, clipped to a sample and
  registered once. A disabled channel outputs zero.
*/

`timescale 1ns/10ps

module prop_ctrl
  import rp_sig_pkg::*, rp_cfg_pkg::*;
(
  input  logic       adc_clk,
  input  logic       arst_n_i,
  input  chan_pair_t smp_i,
  input  core_cfg_t  cfg_i,
  output chan_pair_t ctl_o
);

  //////////////////////////////////////////////////////////////////////
  // per-channel term
  //////////////////////////////////////////////////////////////////////

  // error gets one extra bit so sp - x cannot wrap
  function automatic sample_t p_term(
    input sample_t sp,
    input sample_t x,
    input kp_t     kp
  );
    logic signed [SMP_W:0]              err;
    logic signed [SMP_W+$bits(kp_t):0]  prod;   // 15 x 8 bits
    err  = sp - x;
    prod = err * kp;
    // arithmetic shift drops the gain fraction
    return sat_smp(int'(prod >>> KP_SHIFT));
  endfunction

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctl_o <= '0;
    end else begin
      // channel A
      if (cfg_i.ctl_a_en)
        ctl_o.a <= p_term(cfg_i.sp_a, smp_i.a, cfg_i.kp_a);
      else
        ctl_o.a <= '0;
      // channel B
      if (cfg_i.ctl_b_en)
        ctl_o.b <= p_term(cfg_i.sp_b, smp_i.b, cfg_i.kp_b);
      else
        ctl_o.b <= '0;
    end
  end

endmodule

// ==== logic/offset_gen.sv ====
/*
  DC offset plus optional square wave for both channels.
  One half-period counter flips a shared phase; each channel adds or
  subtracts the amplitude from its own offset, clipped, registered.
*/

`timescale 1ns/10ps

module offset_gen
  import rp_sig_pkg::*, rp_cfg_pkg::*;
(
  input  logic       adc_clk,
  input  logic       arst_n_i,
  input  core_cfg_t  cfg_i,
  output chan_pair_t gen_o
);

  logic [HALF_W-1:0] cnt_q;
  logic [HALF_W:0]   cnt_nxt;   // extra bit, compare never wraps
  logic              phase_q;   // 0: +amp, 1: -amp
  int                amp_s;     // signed step applied to both

  assign cnt_nxt = cnt_q + 1'b1;

  // half period counter, parked at 0 while square is off
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q   <= '0;
      phase_q <= 1'b0;
    end else if (!cfg_i.sq_en) begin
      cnt_q   <= '0;
      phase_q <= 1'b0;
    end else if (cnt_nxt >= {1'b0, cfg_i.half}) begin
      cnt_q   <= '0;
      phase_q <= ~phase_q;           // end of half period
    end else begin
      cnt_q   <= cnt_nxt[HALF_W-1:0];
    end
  end

  always_comb begin
    if (!cfg_i.sq_en)
      amp_s = 0;
    else if (phase_q)
      amp_s = -int'(cfg_i.amp);
    else
      amp_s = int'(cfg_i.amp);
  end

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gen_o <= '0;
    end else begin
      gen_o.a <= sat_smp(int'(cfg_i.ofs_a) + amp_s);
      gen_o.b <= sat_smp(int'(cfg_i.ofs_b) + amp_s);
    end
  end

endmodule

// ==== logic/dac_mixer.sv ====
/*
  Output mixer. Adds controller and generator per channel, clips the sum to
  14 bits and registers both the signed value (for loopback) and the
  negative-slope DAC code.
*/

`timescale 1ns/10ps

module dac_mixer
  import rp_sig_pkg::*;
(
  input  logic       adc_clk,
  input  logic       arst_n_i,
  input  chan_pair_t ctl_i,
  input  chan_pair_t gen_i,
  output chan_pair_t mix_o,
  output dac_pair_t  dac_o
);

  chan_pair_t mix_d;

  // sum with one guard bit, top two bits differ on overflow
  function automatic sample_t mix_sat(input sample_t x, input sample_t y);
    logic signed [SUM_W-1:0] sum;
    sum = x + y;
    if (^sum[SUM_W-1 -: 2])
      return {sum[SUM_W-1], {(SMP_W-1){~sum[SUM_W-1]}}};  // rail by sign
    return sum[SMP_W-1:0];
  endfunction

  assign mix_d.a = mix_sat(ctl_i.a, gen_i.a);
  assign mix_d.b = mix_sat(ctl_i.b, gen_i.b);

  //////////////////////////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mix_o   <= '0;
      dac_o.a <= smp_to_code('0);    // mid scale, 0x1FFF
      dac_o.b <= smp_to_code('0);
    end else begin
      mix_o   <= mix_d;
      dac_o.a <= smp_to_code(mix_d.a);
      dac_o.b <= smp_to_code(mix_d.b);
    end
  end

endmodule

// ==== logic/hk_regs.sv ====
/*
  APB3 register file of the analog core.
  No wait states; read data and error are decoded in the setup phase and
  presented in the access phase. Writes land on the access-phase edge.
*/

`timescale 1ns/10ps

module hk_regs
  import rp_cfg_pkg::*;
(
  input  logic              adc_clk,
  input  logic              arst_n_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [APB_AW-1:0] paddr_i,
  input  logic [APB_DW-1:0] pwdata_i,
  output logic [APB_DW-1:0] prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  output core_cfg_t         cfg_o
);

  core_cfg_t         cfg_q;
  logic              setup;     // first cycle of a transfer
  logic              access;    // second cycle
  logic              hit;       // address is mapped
  logic              wr_en;
  logic [APB_DW-1:0] rd_val;
  logic [APB_DW-1:0] rdata_q;
  logic              slverr_q;

  assign setup  = psel_i & ~penable_i;
  assign access = psel_i &  penable_i;

  //////////////////////////////////////////////////////////////////////
  // address decode and read mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    hit    = 1'b1;
    rd_val = '0;
    case (paddr_i)
      REG_CTRL:  rd_val = APB_DW'({cfg_q.sq_en, cfg_q.ctl_b_en,
                                   cfg_q.ctl_a_en, cfg_q.dig_loop});
      REG_ID:    rd_val = CORE_ID;
      REG_SP_A:  rd_val = APB_DW'(cfg_q.sp_a);    // sign extended
      REG_SP_B:  rd_val = APB_DW'(cfg_q.sp_b);
      REG_KP_A:  rd_val = APB_DW'(cfg_q.kp_a);
      REG_KP_B:  rd_val = APB_DW'(cfg_q.kp_b);
      REG_OFS_A: rd_val = APB_DW'(cfg_q.ofs_a);
      REG_OFS_B: rd_val = APB_DW'(cfg_q.ofs_b);
      REG_AMP:   rd_val = APB_DW'(cfg_q.amp);
      REG_HALF:  rd_val = APB_DW'(cfg_q.half);    // unsigned count
      default:   hit    = 1'b0;
    endcase
  end

  // REG_ID is never written
  assign wr_en = access & pwrite_i & hit & (paddr_i != REG_ID);

  //////////////////////////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q <= '0;
    end else if (wr_en) begin
      case (paddr_i)
        REG_CTRL: begin
          cfg_q.dig_loop <= pwdata_i[0];
          cfg_q.ctl_a_en <= pwdata_i[1];
          cfg_q.ctl_b_en <= pwdata_i[2];
          cfg_q.sq_en    <= pwdata_i[3];
        end
        REG_SP_A:  cfg_q.sp_a  <= pwdata_i[$bits(cfg_q.sp_a)-1:0];
        REG_SP_B:  cfg_q.sp_b  <= pwdata_i[$bits(cfg_q.sp_b)-1:0];
        REG_KP_A:  cfg_q.kp_a  <= pwdata_i[$bits(kp_t)-1:0];
        REG_KP_B:  cfg_q.kp_b  <= pwdata_i[$bits(kp_t)-1:0];
        REG_OFS_A: cfg_q.ofs_a <= pwdata_i[$bits(cfg_q.ofs_a)-1:0];
        REG_OFS_B: cfg_q.ofs_b <= pwdata_i[$bits(cfg_q.ofs_b)-1:0];
        REG_AMP:   cfg_q.amp   <= pwdata_i[$bits(cfg_q.amp)-1:0];
        REG_HALF:  cfg_q.half  <= pwdata_i[HALF_W-1:0];
        default:   cfg_q       <= cfg_q;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response, valid only in the access phase
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_q  <= '0;
      slverr_q <= 1'b0;
    end else begin
      rdata_q  <= (setup && !pwrite_i) ? rd_val : '0;   // idle bus reads 0
      slverr_q <= setup & (~hit | (pwrite_i & (paddr_i == REG_ID)));
    end
  end

  assign prdata_o  = rdata_q;
  assign pslverr_o = slverr_q;
  assign pready_o  = 1'b1;          // never stalls
  assign cfg_o     = cfg_q;

endmodule

// ==== logic/rp_core_top.sv ====
/*
  Analog core top. ADC capture, proportional controller, offset generator
  and DAC mixer, configured over APB. Pins to DAC take four cycles.
*/

`timescale 1ns/10ps

module rp_core_top
  import rp_sig_pkg::*, rp_cfg_pkg::*;
(
  input  logic              adc_clk,
  input  logic              arst_n_i,
  // APB3 slave
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [APB_AW-1:0] paddr_i,
  input  logic [APB_DW-1:0] pwdata_i,
  output logic [APB_DW-1:0] prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  // converters
  input  adc_code_t         adc_a_i,
  input  adc_code_t         adc_b_i,
  output adc_code_t         dac_a_o,
  output adc_code_t         dac_b_o
);

  core_cfg_t  cfg;
  chan_pair_t smp;     // frontend samples
  chan_pair_t ctl;     // controller terms
  chan_pair_t gen;     // offset / square
  chan_pair_t mix;     // registered mixer result, loopback source
  dac_pair_t  dac;

  hk_regs i_hk (
    .adc_clk   (adc_clk  ),
    .arst_n_i  (arst_n_i ),
    .psel_i    (psel_i   ),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i ),
    .paddr_i   (paddr_i  ),
    .pwdata_i  (pwdata_i ),
    .prdata_o  (prdata_o ),
    .pready_o  (pready_o ),
    .pslverr_o (pslverr_o),
    .cfg_o     (cfg      )
  );

  adc_frontend i_fe (
    .adc_clk  (adc_clk ),
    .arst_n_i (arst_n_i),
    .adc_a_i  (adc_a_i ),
    .adc_b_i  (adc_b_i ),
    .cfg_i    (cfg     ),
    .loop_i   (mix     ),
    .smp_o    (smp     )
  );

  prop_ctrl i_ctl (
    .adc_clk  (adc_clk ),
    .arst_n_i (arst_n_i),
    .smp_i    (smp     ),
    .cfg_i    (cfg     ),
    .ctl_o    (ctl     )
  );

  offset_gen i_gen (
    .adc_clk  (adc_clk ),
    .arst_n_i (arst_n_i),
    .cfg_i    (cfg     ),
    .gen_o    (gen     )
  );

  dac_mixer i_mix (
    .adc_clk  (adc_clk ),
    .arst_n_i (arst_n_i),
    .ctl_i    (ctl     ),
    .gen_i    (gen     ),
    .mix_o    (mix     ),
    .dac_o    (dac     )
  );

  assign dac_a_o = dac.a;
  assign dac_b_o = dac.b;

endmodule

// ==== dv/rp_core_checker.sv ====
/*
  Concurrent checks on the APB slave and its reset state.
  Bound into hk_regs from the testbench.
*/

`timescale 1ns/10ps

module rp_core_checker
  import rp_cfg_pkg::*;
(
  input logic      adc_clk,
  input logic      arst_n_i,
  input logic      psel_i,
  input logic      penable_i,
  input logic      pready_i,
  input logic      pslverr_i,
  input core_cfg_t cfg_i
);

  // no wait states so ready whenever selected
  a_ready: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    psel_i |-> pready_i)
    else $error("pready low while psel is set");

  // error flag only next to an access phase
  a_err_phase: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    pslverr_i |-> (psel_i && penable_i))
    else $error("pslverr set outside an access phase");

  a_cfg_rst: assert property (@(posedge adc_clk)
    !arst_n_i |=> (cfg_i == '0))     // ID is a constant outside cfg
    else $error("configuration not cleared during reset");

endmodule

// ==== dv/rp_core_tb.sv ====
/*
  Testbench for the analog core. Reads operations and expected values from
  dv/rp_stimulus.txt, drives APB transfers and ADC pins, checks readback,
  slave errors and settled DAC codes, then prints one summary line.
*/

`timescale 1ns/10ps

module rp_core_tb import rp_sig_pkg::*, rp_cfg_pkg::*;;

  localparam int LAT = 4;                // ADC pins to DAC, cycles
  localparam int TMO = 16;               // cycles before a wait gives up

  logic              adc_clk = 1'b0;
  logic              arst_n;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_AW-1:0] paddr;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pready;
  logic              pslverr;
  adc_code_t         adc_a;
  adc_code_t         adc_b;
  adc_code_t         dac_a;
  adc_code_t         dac_b;
  logic [31:0]       stim [0:255];       // 4 words per operation
  int                errors;
  int                checks;
  logic              aborted;            // timeout or bad stimulus

  rp_core_top dut0 (
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr),
    .adc_a_i   (adc_a),
    .adc_b_i   (adc_b),
    .dac_a_o   (dac_a),
    .dac_b_o   (dac_b)
  );

  bind hk_regs rp_core_checker chk0 (
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pready_i  (pready_o),
    .pslverr_i (pslverr_o),
    .cfg_i     (cfg_o)
  );

  always #2 adc_clk = ~adc_clk;          // 4 ns period

  ///////////////////////////////////////////////////////////////////////
  // helpers
  ///////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] dac_word();
    return {2'b00, dac_a, 2'b00, dac_b};  // same packing as the file
  endfunction

  task automatic check_val(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else begin
      errors++;
      $display("[FAIL] %0d ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // one APB3 transfer, setup then access
  task automatic apb_xfer(input logic wr, input logic [31:0] addr,
                          input logic [31:0] wd, output logic [31:0] rd,
                          output logic err);
    int n;
    @(posedge adc_clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr[APB_AW-1:0];
    pwdata  <= wd;
    @(posedge adc_clk);
    penable <= 1'b1;                     // access phase
    @(negedge adc_clk);
    n = 0;
    while (!pready && n < TMO) begin
      @(negedge adc_clk);
      n++;
    end
    if (!pready) begin
      $display("timeout: no pready on APB access to address %h", addr);
      aborted = 1'b1;
    end
    rd  = prdata;                        // mid-cycle, stable
    err = pslverr;
    @(posedge adc_clk);                  // write lands on this edge
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // flush the pipe, then wait for two equal DAC samples
  task automatic settle();
    int          n;
    logic [31:0] prev;
    n    = 0;
    prev = 'x;
    while (n < TMO && !(n > LAT && dac_word() === prev)) begin
      prev = dac_word();
      @(negedge adc_clk);
      n++;
    end
    if (n >= TMO) begin
      $display("timeout: DAC outputs did not settle after ADC change");
      aborted = 1'b1;
    end
  endtask

  // square wave: only two levels allowed, both must show up
  task automatic square_scan(input int cycles, input logic [31:0] hi,
                             input logic [31:0] lo);
    int          i;
    logic [31:0] cur;
    logic        seen_hi;
    logic        seen_lo;
    seen_hi = 1'b0;
    seen_lo = 1'b0;
    for (i = 0; i < cycles; i++) begin
      @(negedge adc_clk);
      cur = dac_word();
      if (i >= LAT) begin                // skip the enable transient
        checks++;
        assert (cur === hi || cur === lo)
        else begin
          errors++;
          $display("[FAIL] %0d ns: square level %h is neither %h nor %h",
                   $time, cur, hi, lo);
        end
        seen_hi |= (cur === hi);
        seen_lo |= (cur === lo);
      end
    end
    checks++;
    assert (seen_hi && seen_lo)
    else begin
      errors++;
      $display("square wave did not show both levels within %0d cycles", cycles);
    end
  endtask

  ///////////////////////////////////////////////////////////////////////
  // main sequence
  ///////////////////////////////////////////////////////////////////////

  initial begin
    int          idx;
    logic [31:0] op;
    logic [31:0] arg;
    logic [31:0] dat;
    logic [31:0] exp;
    logic [31:0] rd;
    logic        err;
    errors  = 0;
    checks  = 0;
    aborted = 1'b0;
    arst_n  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    adc_a   = '0;
    adc_b   = '0;
    $readmemh("dv/rp_stimulus.txt", stim);
    repeat (4) @(posedge adc_clk);
    arst_n <= 1'b1;
    idx = 0;
    while (!aborted && idx < 64 && stim[4*idx] !== 32'h0) begin
      op  = stim[4*idx];
      arg = stim[4*idx+1];
      dat = stim[4*idx+2];
      exp = stim[4*idx+3];
      case (op)
        1: begin                         // write, expect pslverr
          apb_xfer(1'b1, arg, dat, rd, err);
          check_val($sformatf("pslverr on write %h", arg[11:0]), {31'b0, err}, exp);
        end
        2: begin                         // read, pslverr in data column
          apb_xfer(1'b0, arg, '0, rd, err);
          check_val($sformatf("pslverr on read %h", arg[11:0]), {31'b0, err}, dat);
          check_val($sformatf("prdata of %h", arg[11:0]), rd, exp);
        end
        3: begin                         // ADC pair in, DAC pair out
          @(posedge adc_clk);
          adc_a <= arg[16 +: SMP_W];
          adc_b <= arg[0 +: SMP_W];
          settle();
          check_val($sformatf("DAC pair for ADC %h", arg), dac_word(), exp);
        end
        4: square_scan(int'(arg), dat, exp);
        default: begin
          $display("unknown operation %h on stimulus entry %0d", op, idx);
          errors++;
          aborted = 1'b1;
        end
      endcase
      idx++;
    end
    $display("checks %0d, errors %0d, aborted %0d", checks, errors, aborted);
    if (errors == 0 && !aborted) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== dv/rp_stimulus.txt ====
// op arg data expect, hex | 1 write: addr wdata pslverr | 2 read: addr pslverr prdata
// 3 sample: {adc_a,adc_b} 0 {dac_a,dac_b} | 4 square: cycles {dac hi} {dac lo} | 0 end
2 004 0 52500001          // ID after reset
2 000 0 00000000
2 02C 0 00000000
3 00003FFF 0 1FFF1FFF     // mid scale after reset
1 010 00000100 0          // SP_A 256
2 010 0 00000100
1 01C 000000E8 0          // KP_B -24
2 01C 0 FFFFFFE8
1 030 00000000 1          // unmapped write
2 100 1 00000000          // unmapped read
1 004 12345678 1          // ID is read only
2 004 0 52500001
1 020 00000500 0          // OFS_A 1280
1 024 FFFFFC18 0          // OFS_B -1000
3 12340ABC 0 1AFF23E7
1 020 00001FFF 0          // full scale offsets
1 024 FFFFE000 0
3 12340ABC 0 00003FFF
1 020 00000064 0          // OFS_A 100
1 024 00000000 0
1 018 0000004B 0          // KP_A 75
1 014 FFFFF830 0          // SP_B -2000
1 000 00000006 0          // both controllers on
3 1ED31E0B 0 1FCF1C56
3 3FFF0000 0 00001112     // controller A clips high
1 024 FFFFE0C0 0          // OFS_B -8000
3 3FFF3FFF 0 00003FFF     // mixer B clips low
1 000 00000001 0          // digital loop, offsets only
3 12340ABC 0 1F9B3F3F
3 3FFF0000 0 1F9B3F3F
1 028 00000800 0          // amplitude 2048
1 02C 00000005 0          // half period 5
1 000 00000008 0          // square on
4 00000018 179B373F 279B3FFF
0 0 0 0

// ==== flist.f ====
logic/rp_sig_pkg.sv
logic/rp_cfg_pkg.sv
logic/adc_frontend.sv
logic/prop_ctrl.sv
logic/offset_gen.sv
logic/dac_mixer.sv
logic/hk_regs.sv
logic/rp_core_top.sv
dv/rp_core_checker.sv
dv/rp_core_tb.sv
